//--- rtl/spu_defs.svh
// --------------------------------------------------
// SPU shared constants: sample period, FIFO depth,
// register offsets, control bits, CD ring bases
// --------------------------------------------------
`ifndef SPU_DEFS_SVH
`define SPU_DEFS_SVH

// Clocks per audio sample (44.1 kHz at 33.8 MHz)
`define SPU_SAMPLE_CYCLES    768
// Transfer FIFO holds 2^5 = 32 halfwords
`define SPU_FIFO_DEPTH_LOG2  5

// CPU register byte offsets
`define SPU_REG_IRQ_ADDR     10'h1A4
`define SPU_REG_XFER_ADDR    10'h1A6
`define SPU_REG_XFER_FIFO    10'h1A8
`define SPU_REG_CTRL         10'h1AA
`define SPU_REG_STAT         10'h1AE
`define SPU_REG_CD_VOL_L     10'h1B0
`define SPU_REG_CD_VOL_R     10'h1B2

// Control register bit positions
`define SPU_CTRL_ENABLE      15
`define SPU_CTRL_UNMUTE      14
`define SPU_CTRL_IRQ_EN      6
// Mode field occupies bits 5:4
`define SPU_CTRL_MODE_LSB    4
`define SPU_CTRL_CD_EN       0

// CD ring buffers, halfword addresses in sound RAM
`define SPU_CD_RING_L        18'h00000
`define SPU_CD_RING_R        18'h00200

`endif

//--- rtl/spu_pkg.sv
// --------------------------------------------------
// SPU package: vector types and state enums
// --------------------------------------------------
package spuPkg;

	// Register or sound RAM data word
	typedef logic [15:0] spuData_t;

	// Signed audio sample, also used for CD volumes
	typedef logic signed [15:0] cdSample_t;

	// Halfword address over 512 KB of sound RAM
	typedef logic [17:0] ramAddr_t;

	// CPU byte address inside the SPU window
	typedef logic [9:0] regAddr_t;

	// Position inside a 512-entry CD ring buffer
	typedef logic [8:0] ringIndex_t;

	// Transfer mode, control bits 5:4
	// DMA read is kept as a code only and acts like stop
	typedef enum logic [1:0]
	{
		XFER_STOP   = 2'd0,
		XFER_MANUAL = 2'd1,
		XFER_DMAWR  = 2'd2,
		XFER_DMARD  = 2'd3
	} xferMode_t;

	// CD write-back sequencer
	typedef enum logic [1:0]
	{
		CD_IDLE = 2'd0,
		CD_WR_L = 2'd1,
		CD_WR_R = 2'd2
	} cdWbState_t;

endpackage

//--- rtl/spu_regs.sv
// --------------------------------------------------
// SPU CPU register front end: write decode, FIFO
// push strobe, address reload and read reply
// --------------------------------------------------
`timescale 1ns/1ps
`include "spu_defs.svh"

module spu_regs
(
	input  logic              i_clk,
	input  logic              i_rstN,
	input  logic              i_SPUCS,
	input  logic              i_SRD,
	input  logic              i_SWRO,
	input  spuPkg::regAddr_t  i_addr,
	input  spuPkg::spuData_t  i_dataIn,
	input  logic              i_busy,
	input  logic              i_irqFlag,
	output spuPkg::spuData_t  o_dataOut,
	output logic              o_dataOutValid,
	output logic              o_fifoPush,
	output spuPkg::spuData_t  o_irqAddr,
	output spuPkg::spuData_t  o_xferAddr,
	output logic              o_xferAddrLoad,
	output spuPkg::xferMode_t o_mode,
	output logic              o_irqEnable,
	output spuPkg::cdSample_t o_cdVolL,
	output spuPkg::cdSample_t o_cdVolR,
	output logic              o_cdOutEnable
);
	import spuPkg::*;

	logic      cpuWrite;
	logic      cpuRead;
	spuData_t  ctrlReg;
	spuData_t  irqAddrReg;
	spuData_t  xferAddrReg;
	cdSample_t cdVolLReg;
	cdSample_t cdVolRReg;
	spuData_t  statWord;
	spuData_t  readMux;

	// Strobes are level qualified by chip select, one access per cycle
	assign cpuWrite = i_SPUCS & i_SWRO;
	assign cpuRead  = i_SPUCS & i_SRD;

	// --------------------------------------------------
	// Register writes
	// --------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rstN)
	begin
		if (!i_rstN)
		begin
			ctrlReg        <= '0;
			irqAddrReg     <= '0;
			xferAddrReg    <= '0;
			cdVolLReg      <= '0;
			cdVolRReg      <= '0;
			o_xferAddrLoad <= 1'b0;
		end
		else
		begin
			// Counter reload lands one cycle later, once the new value is visible
			o_xferAddrLoad <= cpuWrite && (i_addr == `SPU_REG_XFER_ADDR);
			if (cpuWrite)
			begin
				case (i_addr)
					`SPU_REG_CTRL:      ctrlReg     <= i_dataIn;
					`SPU_REG_IRQ_ADDR:  irqAddrReg  <= i_dataIn;
					`SPU_REG_XFER_ADDR: xferAddrReg <= i_dataIn;
					`SPU_REG_CD_VOL_L:  cdVolLReg   <= i_dataIn;
					`SPU_REG_CD_VOL_R:  cdVolRReg   <= i_dataIn;
					default:            ;
				endcase
			end
		end
	end

	// Data port write feeds the FIFO in the same cycle
	assign o_fifoPush = cpuWrite && (i_addr == `SPU_REG_XFER_FIFO);

	// --------------------------------------------------
	// Read reply, one cycle after the strobe
	// --------------------------------------------------
	always_comb
	begin
		statWord     = '0;
		// Status mirrors the low control bits
		statWord[5:0] = ctrlReg[5:0];
		statWord[6]   = i_irqFlag;
		// Transfer busy while words are still queued
		statWord[10]  = i_busy;
	end

	always_comb
	begin
		case (i_addr)
			`SPU_REG_CTRL:      readMux = ctrlReg;
			`SPU_REG_STAT:      readMux = statWord;
			`SPU_REG_IRQ_ADDR:  readMux = irqAddrReg;
			`SPU_REG_XFER_ADDR: readMux = xferAddrReg;
			`SPU_REG_CD_VOL_L:  readMux = cdVolLReg;
			`SPU_REG_CD_VOL_R:  readMux = cdVolRReg;
			// FIFO port and unmapped offsets read as zero
			default:            readMux = '0;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rstN)
	begin
		if (!i_rstN)
		begin
			o_dataOut      <= '0;
			o_dataOutValid <= 1'b0;
		end
		else
		begin
			o_dataOutValid <= cpuRead;
			o_dataOut      <= readMux;
		end
	end

	// Register fields out to the datapath
	assign o_irqAddr     = irqAddrReg;
	assign o_xferAddr    = xferAddrReg;
	assign o_mode        = xferMode_t'(ctrlReg[`SPU_CTRL_MODE_LSB +: 2]);
	assign o_irqEnable   = ctrlReg[`SPU_CTRL_IRQ_EN];
	assign o_cdVolL      = cdVolLReg;
	assign o_cdVolR      = cdVolRReg;
	// CD reaches the DAC only when enabled, unmuted and CD audio on
	assign o_cdOutEnable = ctrlReg[`SPU_CTRL_ENABLE] & ctrlReg[`SPU_CTRL_UNMUTE]
		& ctrlReg[`SPU_CTRL_CD_EN];

endmodule

//--- rtl/spu_xfer_fifo.sv
// --------------------------------------------------
// SPU transfer FIFO, RAM transfer address counter
// and DMA write request
// --------------------------------------------------
`timescale 1ns/1ps
`include "spu_defs.svh"

module spu_xfer_fifo
(
	input  logic              i_clk,
	input  logic              i_rstN,
	input  logic              i_push,
	input  spuPkg::spuData_t  i_dataIn,
	input  logic              i_SPUDACK,
	input  spuPkg::xferMode_t i_mode,
	input  spuPkg::spuData_t  i_xferAddr,
	input  logic              i_xferAddrLoad,
	input  logic              i_xferGrant,
	output logic              o_SPUDREQ,
	output logic              o_xferReq,
	output spuPkg::ramAddr_t  o_xferAddrRam,
	output spuPkg::spuData_t  o_xferData,
	output logic              o_busy
);
	import spuPkg::*;

	localparam int depthLog2 = `SPU_FIFO_DEPTH_LOG2;

	spuData_t              fifoMem [0:(1 << depthLog2) - 1];
	// One extra pointer bit tells full from empty
	logic [depthLog2:0]    wrPtr;
	logic [depthLog2:0]    rdPtr;
	logic                  fifoFull;
	logic                  fifoEmpty;
	logic                  dmaPush;
	logic                  pushEn;
	logic                  drainMode;
	ramAddr_t              xferCnt;

	assign fifoEmpty = (wrPtr == rdPtr);
	assign fifoFull  = (wrPtr[depthLog2] != rdPtr[depthLog2])
		&& (wrPtr[depthLog2-1:0] == rdPtr[depthLog2-1:0]);

	// DMA acknowledge carries a word only in DMA write mode
	assign dmaPush = i_SPUDACK && (i_mode == XFER_DMAWR);
	// Word pushed while full is dropped
	assign pushEn  = (i_push | dmaPush) & ~fifoFull;

	// --------------------------------------------------
	// FIFO storage and pointers
	// --------------------------------------------------
	always_ff @(posedge i_clk)
	begin
		if (pushEn)
		begin
			fifoMem[wrPtr[depthLog2-1:0]] <= i_dataIn;
		end
	end

	always_ff @(posedge i_clk or negedge i_rstN)
	begin
		if (!i_rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (pushEn)
			begin
				wrPtr <= wrPtr + 1'b1;
			end
			// Grant only comes with a request, so the FIFO is not empty here
			if (i_xferGrant)
			begin
				rdPtr <= rdPtr + 1'b1;
			end
		end
	end

	// Head of the FIFO goes straight to the RAM mux
	assign o_xferData = fifoMem[rdPtr[depthLog2-1:0]];

	// --------------------------------------------------
	// Transfer address counter
	// --------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rstN)
	begin
		if (!i_rstN)
		begin
			xferCnt <= '0;
		end
		else if (i_xferAddrLoad)
		begin
			// Register counts 8-byte units, RAM counts halfwords
			xferCnt <= {i_xferAddr, 2'b00};
		end
		else if (i_xferGrant)
		begin
			xferCnt <= xferCnt + 1'b1;
		end
	end

	assign o_xferAddrRam = xferCnt;

	// --------------------------------------------------
	// Requests
	// --------------------------------------------------
	// Stop and DMA read both leave words parked in the FIFO
	assign drainMode = (i_mode == XFER_MANUAL) || (i_mode == XFER_DMAWR);
	assign o_xferReq = ~fifoEmpty & drainMode;
	// Keep asking for DMA words until the FIFO fills
	assign o_SPUDREQ = (i_mode == XFER_DMAWR) & ~fifoFull;
	assign o_busy    = ~fifoEmpty;

endmodule

//--- rtl/spu_cd_capture.sv
// --------------------------------------------------
// SPU CD audio path: sample timer, input latches,
// DAC scaling and ring buffer write-back
// --------------------------------------------------
`timescale 1ns/1ps
`include "spu_defs.svh"

module spu_cd_capture
(
	input  logic              i_clk,
	input  logic              i_rstN,
	input  spuPkg::cdSample_t i_cdInL,
	input  spuPkg::cdSample_t i_cdInR,
	input  logic              i_cdValidL,
	input  logic              i_cdValidR,
	input  spuPkg::cdSample_t i_cdVolL,
	input  spuPkg::cdSample_t i_cdVolR,
	input  logic              i_cdOutEnable,
	input  logic              i_cdGrant,
	output logic              o_cdReq,
	output spuPkg::ramAddr_t  o_cdAddr,
	output spuPkg::spuData_t  o_cdData,
	output spuPkg::cdSample_t o_AOUTL,
	output spuPkg::cdSample_t o_AOUTR,
	output logic              o_validOut
);
	import spuPkg::*;

	localparam logic [9:0] lastCycle = 10'(`SPU_SAMPLE_CYCLES - 1);

	logic [9:0]         sampleCnt;
	logic               tick;
	cdSample_t          latchL;
	cdSample_t          latchR;
	cdSample_t          snapL;
	cdSample_t          snapR;
	logic signed [31:0] prodL;
	logic signed [31:0] prodR;
	logic signed [31:0] shiftL;
	logic signed [31:0] shiftR;
	cdWbState_t         wbState;
	ringIndex_t         ringIdx;

	// Sample period timer
	assign tick = (sampleCnt == lastCycle);

	always_ff @(posedge i_clk or negedge i_rstN)
	begin
		if (!i_rstN)
		begin
			sampleCnt <= '0;
			latchL    <= '0;
			latchR    <= '0;
			snapL     <= '0;
			snapR     <= '0;
		end
		else
		begin
			sampleCnt <= tick ? 10'd0 : sampleCnt + 10'd1;
			// Most recent sample from the drive wins
			if (i_cdValidL)
			begin
				latchL <= i_cdInL;
			end
			if (i_cdValidR)
			begin
				latchR <= i_cdInR;
			end
			// Freeze the pair that this tick writes back
			if (tick)
			begin
				snapL <= latchL;
				snapR <= latchR;
			end
		end
	end

	// --------------------------------------------------
	// DAC output, volume is 1.15 fixed point
	// --------------------------------------------------
	assign prodL  = latchL * i_cdVolL;
	assign prodR  = latchR * i_cdVolR;
	assign shiftL = prodL >>> 15;
	assign shiftR = prodR >>> 15;

	always_ff @(posedge i_clk or negedge i_rstN)
	begin
		if (!i_rstN)
		begin
			o_AOUTL    <= '0;
			o_AOUTR    <= '0;
			o_validOut <= 1'b0;
		end
		else
		begin
			o_validOut <= tick;
			if (tick)
			begin
				o_AOUTL <= i_cdOutEnable ? shiftL[15:0] : '0;
				o_AOUTR <= i_cdOutEnable ? shiftR[15:0] : '0;
			end
		end
	end

	// --------------------------------------------------
	// Ring write-back, left then right per tick
	// --------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rstN)
	begin
		if (!i_rstN)
		begin
			wbState <= CD_IDLE;
			ringIdx <= '0;
		end
		else
		begin
			case (wbState)
				CD_IDLE:
				begin
					if (tick)
					begin
						wbState <= CD_WR_L;
					end
				end
				CD_WR_L:
				begin
					if (i_cdGrant)
					begin
						wbState <= CD_WR_R;
					end
				end
				CD_WR_R:
				begin
					// Index wraps at 512 by width
					if (i_cdGrant)
					begin
						wbState <= CD_IDLE;
						ringIdx <= ringIdx + 1'b1;
					end
				end
				default: wbState <= CD_IDLE;
			endcase
		end
	end

	assign o_cdReq  = (wbState == CD_WR_L) || (wbState == CD_WR_R);
	assign o_cdAddr = (wbState == CD_WR_R) ? `SPU_CD_RING_R + ramAddr_t'(ringIdx)
		: `SPU_CD_RING_L + ramAddr_t'(ringIdx);
	assign o_cdData = (wbState == CD_WR_R) ? snapR : snapL;

endmodule

//--- rtl/spu_ram_port.sv
// --------------------------------------------------
// SPU sound RAM write arbiter and IRQ address watch
// --------------------------------------------------
`timescale 1ns/1ps

module spu_ram_port
(
	input  logic             i_clk,
	input  logic             i_rstN,
	input  logic             i_cdReq,
	input  spuPkg::ramAddr_t i_cdAddr,
	input  spuPkg::spuData_t i_cdData,
	input  logic             i_xferReq,
	input  spuPkg::ramAddr_t i_xferAddr,
	input  spuPkg::spuData_t i_xferData,
	input  spuPkg::spuData_t i_irqAddr,
	input  logic             i_irqEnable,
	output logic             o_cdGrant,
	output logic             o_xferGrant,
	output spuPkg::ramAddr_t o_adrRAM,
	output spuPkg::spuData_t o_dataOutRAM,
	output logic             o_dataWriteRAM,
	output logic             o_irqFlag
);

	// Fixed priority, CD write-back first
	assign o_cdGrant   = i_cdReq;
	assign o_xferGrant = i_xferReq & ~i_cdReq;

	// One write per cycle on the shared port
	assign o_dataWriteRAM = o_cdGrant | o_xferGrant;
	assign o_adrRAM       = o_cdGrant ? i_cdAddr : i_xferAddr;
	assign o_dataOutRAM   = o_cdGrant ? i_cdData : i_xferData;

	// --------------------------------------------------
	// IRQ on a write into the watched 8-byte unit
	// --------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rstN)
	begin
		if (!i_rstN)
		begin
			o_irqFlag <= 1'b0;
		end
		else if (!i_irqEnable)
		begin
			// Clearing enable acknowledges the interrupt
			o_irqFlag <= 1'b0;
		end
		else if (o_dataWriteRAM && (o_adrRAM[17:2] == i_irqAddr))
		begin
			o_irqFlag <= 1'b1;
		end
	end

endmodule

//--- rtl/spu_top.sv
// --------------------------------------------------
// SPU top: registers, transfer FIFO, CD capture
// and RAM port
// --------------------------------------------------
`timescale 1ns/1ps

module spu_top
(
	input  logic              i_clk,
	input  logic              i_rstN,
	input  logic              i_SPUCS,
	input  logic              i_SRD,
	input  logic              i_SWRO,
	input  spuPkg::regAddr_t  i_addr,
	input  spuPkg::spuData_t  i_dataIn,
	input  logic              i_SPUDACK,
	input  spuPkg::cdSample_t i_cdInL,
	input  spuPkg::cdSample_t i_cdInR,
	input  logic              i_cdValidL,
	input  logic              i_cdValidR,
	output spuPkg::spuData_t  o_dataOut,
	output logic              o_dataOutValid,
	output logic              o_SPUINT,
	output logic              o_SPUDREQ,
	output spuPkg::ramAddr_t  o_adrRAM,
	output spuPkg::spuData_t  o_dataOutRAM,
	output logic              o_dataWriteRAM,
	output spuPkg::cdSample_t o_AOUTL,
	output spuPkg::cdSample_t o_AOUTR,
	output logic              o_validOut
);
	import spuPkg::*;

	// Register fields
	logic      fifoPush;
	spuData_t  irqAddr;
	spuData_t  xferAddr;
	logic      xferAddrLoad;
	xferMode_t mode;
	logic      irqEnable;
	cdSample_t cdVolL;
	cdSample_t cdVolR;
	logic      cdOutEnable;
	logic      busy;
	logic      irqFlag;
	// Requesters into the RAM arbiter
	logic      xferReq;
	logic      xferGrant;
	ramAddr_t  xferAddrRam;
	spuData_t  xferData;
	logic      cdReq;
	logic      cdGrant;
	ramAddr_t  cdAddr;
	spuData_t  cdData;

	spu_regs spu_regs_inst
	(
		.i_clk          (i_clk),
		.i_rstN         (i_rstN),
		.i_SPUCS        (i_SPUCS),
		.i_SRD          (i_SRD),
		.i_SWRO         (i_SWRO),
		.i_addr         (i_addr),
		.i_dataIn       (i_dataIn),
		.i_busy         (busy),
		.i_irqFlag      (irqFlag),
		.o_dataOut      (o_dataOut),
		.o_dataOutValid (o_dataOutValid),
		.o_fifoPush     (fifoPush),
		.o_irqAddr      (irqAddr),
		.o_xferAddr     (xferAddr),
		.o_xferAddrLoad (xferAddrLoad),
		.o_mode         (mode),
		.o_irqEnable    (irqEnable),
		.o_cdVolL       (cdVolL),
		.o_cdVolR       (cdVolR),
		.o_cdOutEnable  (cdOutEnable)
	);

	// CPU and DMA words share the data bus
	spu_xfer_fifo spu_xfer_fifo_inst
	(
		.i_clk          (i_clk),
		.i_rstN         (i_rstN),
		.i_push         (fifoPush),
		.i_dataIn       (i_dataIn),
		.i_SPUDACK      (i_SPUDACK),
		.i_mode         (mode),
		.i_xferAddr     (xferAddr),
		.i_xferAddrLoad (xferAddrLoad),
		.i_xferGrant    (xferGrant),
		.o_SPUDREQ      (o_SPUDREQ),
		.o_xferReq      (xferReq),
		.o_xferAddrRam  (xferAddrRam),
		.o_xferData     (xferData),
		.o_busy         (busy)
	);

	spu_cd_capture spu_cd_capture_inst
	(
		.i_clk         (i_clk),
		.i_rstN        (i_rstN),
		.i_cdInL       (i_cdInL),
		.i_cdInR       (i_cdInR),
		.i_cdValidL    (i_cdValidL),
		.i_cdValidR    (i_cdValidR),
		.i_cdVolL      (cdVolL),
		.i_cdVolR      (cdVolR),
		.i_cdOutEnable (cdOutEnable),
		.i_cdGrant     (cdGrant),
		.o_cdReq       (cdReq),
		.o_cdAddr      (cdAddr),
		.o_cdData      (cdData),
		.o_AOUTL       (o_AOUTL),
		.o_AOUTR       (o_AOUTR),
		.o_validOut    (o_validOut)
	);

	spu_ram_port spu_ram_port_inst
	(
		.i_clk          (i_clk),
		.i_rstN         (i_rstN),
		.i_cdReq        (cdReq),
		.i_cdAddr       (cdAddr),
		.i_cdData       (cdData),
		.i_xferReq      (xferReq),
		.i_xferAddr     (xferAddrRam),
		.i_xferData     (xferData),
		.i_irqAddr      (irqAddr),
		.i_irqEnable    (irqEnable),
		.o_cdGrant      (cdGrant),
		.o_xferGrant    (xferGrant),
		.o_adrRAM       (o_adrRAM),
		.o_dataOutRAM   (o_dataOutRAM),
		.o_dataWriteRAM (o_dataWriteRAM),
		.o_irqFlag      (irqFlag)
	);

	assign o_SPUINT = irqFlag;

endmodule

//--- testbench/spu_tb.sv
// --------------------------------------------------
// SPU testbench: stimulus table, reference model,
// RAM write monitor, compare tasks and watchdog
// --------------------------------------------------
`timescale 1ns/1ps
`include "spu_defs.svh"

module spu_tb;
	import spuPkg::*;

	// Table operations
	localparam int OP_WR   = 0;
	localparam int OP_RD   = 1;
	localparam int OP_FIFO = 2;
	localparam int OP_DMA  = 3;
	localparam int OP_IDLE = 4;
	localparam int OP_CD   = 5;
	localparam int OP_TICK = 6;
	localparam int OP_INT  = 7;

	// DUT connections
	logic      clk;
	logic      rstN;
	logic      spuCs;
	logic      sRd;
	logic      sWro;
	regAddr_t  addr;
	spuData_t  dataIn;
	logic      spuDack;
	cdSample_t cdInL;
	cdSample_t cdInR;
	logic      cdValidL;
	logic      cdValidR;
	spuData_t  dataOut;
	logic      dataOutValid;
	logic      spuInt;
	logic      spuDreq;
	ramAddr_t  adrRam;
	spuData_t  dataOutRam;
	logic      dataWriteRam;
	cdSample_t aoutL;
	cdSample_t aoutR;
	logic      validOut;

	// Stimulus table columns
	int        opQ[$];
	regAddr_t  addrQ[$];
	spuData_t  dataQ[$];
	spuData_t  expQ[$];
	int        stepIdx;

	// Reference model state
	integer     seed = 32'hcb5d8693;
	spuData_t   mCtrl;
	spuData_t   mIrqAddr;
	cdSample_t  mVolL;
	cdSample_t  mVolR;
	ramAddr_t   mXferCnt;
	logic       mIrqFlag;
	cdSample_t  cdModelL;
	cdSample_t  cdModelR;
	ringIndex_t ringN;
	int         edgeCnt;

	// Expected RAM writes, popped by the monitor
	ramAddr_t  xferExpAddrQ[$];
	spuData_t  xferExpDataQ[$];
	logic      xferExpIrqQ[$];
	ramAddr_t  cdExpAddrQ[$];
	spuData_t  cdExpDataQ[$];
	ramAddr_t  monAddr;
	spuData_t  monData;
	logic      monIrq;

	spu_top spu_top_inst
	(
		.i_clk          (clk),
		.i_rstN         (rstN),
		.i_SPUCS        (spuCs),
		.i_SRD          (sRd),
		.i_SWRO         (sWro),
		.i_addr         (addr),
		.i_dataIn       (dataIn),
		.i_SPUDACK      (spuDack),
		.i_cdInL        (cdInL),
		.i_cdInR        (cdInR),
		.i_cdValidL     (cdValidL),
		.i_cdValidR     (cdValidR),
		.o_dataOut      (dataOut),
		.o_dataOutValid (dataOutValid),
		.o_SPUINT       (spuInt),
		.o_SPUDREQ      (spuDreq),
		.o_adrRAM       (adrRam),
		.o_dataOutRAM   (dataOutRam),
		.o_dataWriteRAM (dataWriteRam),
		.o_AOUTL        (aoutL),
		.o_AOUTR        (aoutR),
		.o_validOut     (validOut)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------------------------------------
	// Failure reporting and compare tasks
	// --------------------------------------------------
	task automatic stopOnError();
		$display("test failed");
		$fatal(1);
	endtask

	task automatic checkData(input string name, input spuData_t got, input spuData_t exp);
		if (got !== exp)
		begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			stopOnError();
		end
	endtask

	task automatic checkAddr(input string name, input ramAddr_t got, input ramAddr_t exp);
		if (got !== exp)
		begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			stopOnError();
		end
	endtask

	task automatic checkSample(input string name, input cdSample_t got, input cdSample_t exp);
		if (got !== exp)
		begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			stopOnError();
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			stopOnError();
		end
	endtask

	// Volume is 1.15 fixed point, product shifted right by 15
	function automatic cdSample_t scaleCdSample(input cdSample_t s, input cdSample_t v);
		logic signed [31:0] p;
		p = s * v;
		p = p >>> 15;
		return cdSample_t'(p[15:0]);
	endfunction

	// --------------------------------------------------
	// Table building
	// --------------------------------------------------
	task automatic addStep(input int op, input regAddr_t a, input spuData_t d, input spuData_t e);
		opQ.push_back(op);
		addrQ.push_back(a);
		dataQ.push_back(d);
		expQ.push_back(e);
	endtask

	task automatic buildTable();
		// Reset values, then write and read back
		addStep(OP_RD,   `SPU_REG_CTRL,      16'h0000, 16'h0000);
		addStep(OP_RD,   `SPU_REG_XFER_ADDR, 16'h0000, 16'h0000);
		addStep(OP_WR,   `SPU_REG_IRQ_ADDR,  16'h1234, 16'h0000);
		addStep(OP_RD,   `SPU_REG_IRQ_ADDR,  16'h0000, 16'h1234);
		addStep(OP_WR,   `SPU_REG_XFER_ADDR, 16'h0400, 16'h0000);
		addStep(OP_RD,   `SPU_REG_XFER_ADDR, 16'h0000, 16'h0400);
		addStep(OP_WR,   `SPU_REG_CD_VOL_L,  16'h4000, 16'h0000);
		addStep(OP_RD,   `SPU_REG_CD_VOL_L,  16'h0000, 16'h4000);
		addStep(OP_WR,   `SPU_REG_CD_VOL_R,  16'hC000, 16'h0000);
		addStep(OP_RD,   `SPU_REG_CD_VOL_R,  16'h0000, 16'hC000);
		addStep(OP_WR,   `SPU_REG_CTRL,      16'h0010, 16'h0000);
		addStep(OP_RD,   `SPU_REG_CTRL,      16'h0000, 16'h0010);
		// Manual transfer of one block
		addStep(OP_FIFO, 10'h000,            16'd8,    16'h0000);
		addStep(OP_IDLE, 10'h000,            16'h0000, 16'h0000);
		addStep(OP_RD,   `SPU_REG_STAT,      16'h0000, 16'h0010);
		// DMA write continues after the block
		addStep(OP_WR,   `SPU_REG_CTRL,      16'h0020, 16'h0000);
		addStep(OP_DMA,  10'h000,            16'd6,    16'h0000);
		addStep(OP_IDLE, 10'h000,            16'h0000, 16'h0000);
		addStep(OP_RD,   `SPU_REG_STAT,      16'h0000, 16'h0020);
		// Stop mode ignores acknowledges
		addStep(OP_WR,   `SPU_REG_CTRL,      16'h0000, 16'h0000);
		addStep(OP_DMA,  10'h000,            16'd3,    16'h0000);
		addStep(OP_IDLE, 10'h000,            16'h0000, 16'h0000);
		addStep(OP_RD,   `SPU_REG_STAT,      16'h0000, 16'h0000);
		// IRQ on the unit holding words 4 to 7
		addStep(OP_WR,   `SPU_REG_XFER_ADDR, 16'h0500, 16'h0000);
		addStep(OP_WR,   `SPU_REG_IRQ_ADDR,  16'h0501, 16'h0000);
		addStep(OP_WR,   `SPU_REG_CTRL,      16'h0050, 16'h0000);
		addStep(OP_INT,  10'h000,            16'h0000, 16'h0000);
		addStep(OP_FIFO, 10'h000,            16'd8,    16'h0000);
		addStep(OP_IDLE, 10'h000,            16'h0000, 16'h0000);
		addStep(OP_INT,  10'h000,            16'h0000, 16'h0001);
		addStep(OP_RD,   `SPU_REG_STAT,      16'h0000, 16'h0050);
		addStep(OP_WR,   `SPU_REG_CTRL,      16'h0010, 16'h0000);
		addStep(OP_INT,  10'h000,            16'h0000, 16'h0000);
		addStep(OP_RD,   `SPU_REG_STAT,      16'h0000, 16'h0010);
		// CD audio, enabled and unmuted with CD off first, then CD on
		addStep(OP_WR,   `SPU_REG_CTRL,      16'hC000, 16'h0000);
		addStep(OP_CD,   10'h000,            16'h2000, 16'h8000);
		addStep(OP_TICK, 10'h000,            16'h0000, 16'h0000);
		addStep(OP_WR,   `SPU_REG_CTRL,      16'hC001, 16'h0000);
		addStep(OP_RD,   `SPU_REG_CTRL,      16'h0000, 16'hC001);
		addStep(OP_RD,   `SPU_REG_STAT,      16'h0000, 16'h0001);
		addStep(OP_CD,   10'h000,            16'h1234, 16'hF00D);
		addStep(OP_TICK, 10'h000,            16'h0000, 16'h0000);
		addStep(OP_CD,   10'h000,            16'h8000, 16'h7FFF);
		addStep(OP_TICK, 10'h000,            16'h0000, 16'h0000);
	endtask

	// --------------------------------------------------
	// Bus operations, entered and left 1 ns after a rising edge
	// --------------------------------------------------
	task automatic writeReg(input regAddr_t a, input spuData_t d);
		spuCs  = 1'b1;
		sWro   = 1'b1;
		addr   = a;
		dataIn = d;
		case (a)
			`SPU_REG_CTRL:
			begin
				mCtrl = d;
				// Dropping enable clears a pending interrupt
				if (!d[`SPU_CTRL_IRQ_EN])
				begin
					mIrqFlag = 1'b0;
				end
			end
			`SPU_REG_IRQ_ADDR:  mIrqAddr = d;
			`SPU_REG_XFER_ADDR: mXferCnt = {d, 2'b00};
			`SPU_REG_CD_VOL_L:  mVolL = d;
			`SPU_REG_CD_VOL_R:  mVolR = d;
			default:            ;
		endcase
		@(posedge clk);
		#1;
		spuCs = 1'b0;
		sWro  = 1'b0;
		// One idle cycle lets reload and IRQ clear settle
		@(posedge clk);
		#1;
	endtask

	task automatic readReg(input regAddr_t a, input spuData_t exp);
		spuCs = 1'b1;
		sRd   = 1'b1;
		addr  = a;
		checkFlag("o_dataOutValid", dataOutValid, 1'b0);
		@(posedge clk);
		#1;
		spuCs = 1'b0;
		sRd   = 1'b0;
		// Reply exactly one cycle after the strobe
		checkFlag("o_dataOutValid", dataOutValid, 1'b1);
		checkData("o_dataOut", dataOut, exp);
		@(posedge clk);
		#1;
		checkFlag("o_dataOutValid", dataOutValid, 1'b0);
	endtask

	// Next RAM write of the transfer engine
	task automatic expectXfer(input spuData_t word);
		xferExpAddrQ.push_back(mXferCnt);
		xferExpDataQ.push_back(word);
		xferExpIrqQ.push_back(mIrqFlag);
		if (mCtrl[`SPU_CTRL_IRQ_EN] && (mXferCnt[17:2] == mIrqAddr))
		begin
			mIrqFlag = 1'b1;
		end
		mXferCnt = mXferCnt + 1'b1;
	endtask

	task automatic pushFifoWords(input int n);
		logic [31:0] rnd;
		for (int k = 0; k < n; k++)
		begin
			rnd    = $random(seed);
			spuCs  = 1'b1;
			sWro   = 1'b1;
			addr   = `SPU_REG_XFER_FIFO;
			dataIn = rnd[15:0];
			expectXfer(rnd[15:0]);
			@(posedge clk);
			#1;
		end
		spuCs = 1'b0;
		sWro  = 1'b0;
	endtask

	task automatic dmaWords(input int n);
		logic [31:0] rnd;
		logic        dmaMode;
		dmaMode = (xferMode_t'(mCtrl[`SPU_CTRL_MODE_LSB +: 2]) == XFER_DMAWR);
		for (int k = 0; k < n; k++)
		begin
			rnd = $random(seed);
			// FIFO never fills here, so request follows the mode
			checkFlag("o_SPUDREQ", spuDreq, dmaMode);
			spuDack = 1'b1;
			dataIn  = rnd[15:0];
			if (dmaMode)
			begin
				expectXfer(rnd[15:0]);
			end
			@(posedge clk);
			#1;
		end
		spuDack = 1'b0;
	endtask

	// Wait for the RAM write strobe to take every queued word
	task automatic waitDrained();
		int waitCnt;
		waitCnt = 0;
		while (xferExpAddrQ.size() != 0)
		begin
			@(posedge clk);
			#1;
			waitCnt++;
			if (waitCnt > 64)
			begin
				$display("Transfer words never reached sound RAM");
				stopOnError();
			end
		end
	endtask

	// Returns at the falling edge where o_validOut is high
	task automatic waitTick();
		int waitCnt;
		waitCnt = 0;
		@(negedge clk);
		while (!validOut)
		begin
			@(negedge clk);
			waitCnt++;
			if (waitCnt > 2 * `SPU_SAMPLE_CYCLES)
			begin
				$display("No sample tick arrived within two sample periods");
				stopOnError();
			end
		end
	endtask

	// Sample goes in right after a tick, far from the next one
	task automatic driveCdPair(input cdSample_t l, input cdSample_t r);
		waitTick();
		@(posedge clk);
		#1;
		cdInL    = l;
		cdInR    = r;
		cdValidL = 1'b1;
		cdValidR = 1'b1;
		@(posedge clk);
		#1;
		cdValidL = 1'b0;
		cdValidR = 1'b0;
	endtask

	task automatic checkDacTick();
		logic en;
		en = mCtrl[`SPU_CTRL_ENABLE] & mCtrl[`SPU_CTRL_UNMUTE] & mCtrl[`SPU_CTRL_CD_EN];
		waitTick();
		checkSample("o_AOUTL", aoutL, en ? scaleCdSample(cdModelL, mVolL) : cdSample_t'(0));
		checkSample("o_AOUTR", aoutR, en ? scaleCdSample(cdModelR, mVolR) : cdSample_t'(0));
		@(posedge clk);
		#1;
	endtask

	// --------------------------------------------------
	// Sample timer and CD latch model
	// --------------------------------------------------
	always @(posedge clk)
	begin
		if (rstN)
		begin
			edgeCnt = edgeCnt + 1;
			// Tick edge snapshots the latches for write-back
			if ((edgeCnt % `SPU_SAMPLE_CYCLES) == 0)
			begin
				cdExpAddrQ.push_back(`SPU_CD_RING_L + ramAddr_t'(ringN));
				cdExpDataQ.push_back(cdModelL);
				cdExpAddrQ.push_back(`SPU_CD_RING_R + ramAddr_t'(ringN));
				cdExpDataQ.push_back(cdModelR);
				ringN = ringN + 1'b1;
			end
			if (cdValidL)
			begin
				cdModelL = cdInL;
			end
			if (cdValidR)
			begin
				cdModelR = cdInR;
			end
		end
	end

	// --------------------------------------------------
	// RAM write monitor, mid-cycle
	// --------------------------------------------------
	always @(negedge clk)
	begin
		if (rstN)
		begin
			checkFlag("o_validOut", validOut,
				((edgeCnt % `SPU_SAMPLE_CYCLES) == 0) && (edgeCnt != 0));
			if (dataWriteRam)
			begin
				// Both rings sit below halfword 0x400
				if (adrRam < 18'h00400)
				begin
					if (cdExpAddrQ.size() == 0)
					begin
						$display("CD ring written with no sample tick pending");
						stopOnError();
					end
					monAddr = cdExpAddrQ.pop_front();
					monData = cdExpDataQ.pop_front();
					checkAddr("o_adrRAM", adrRam, monAddr);
					checkData("o_dataOutRAM", dataOutRam, monData);
				end
				else
				begin
					if (xferExpAddrQ.size() == 0)
					begin
						$display("Transfer write to sound RAM with no word queued");
						stopOnError();
					end
					monAddr = xferExpAddrQ.pop_front();
					monData = xferExpDataQ.pop_front();
					monIrq  = xferExpIrqQ.pop_front();
					checkAddr("o_adrRAM", adrRam, monAddr);
					checkData("o_dataOutRAM", dataOutRam, monData);
					// Interrupt shows only after the matching write
					checkFlag("o_SPUINT", spuInt, monIrq);
				end
			end
		end
	end

	// Watchdog sized from the table length
	initial
	begin
		#1;
		repeat (opQ.size() * 2 * `SPU_SAMPLE_CYCLES) @(posedge clk);
		$display("Simulation timed out before the stimulus table finished");
		stopOnError();
	end

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial
	begin
		rstN     = 1'b0;
		spuCs    = 1'b0;
		sRd      = 1'b0;
		sWro     = 1'b0;
		addr     = '0;
		dataIn   = '0;
		spuDack  = 1'b0;
		cdInL    = '0;
		cdInR    = '0;
		cdValidL = 1'b0;
		cdValidR = 1'b0;
		mCtrl    = '0;
		mIrqAddr = '0;
		mVolL    = '0;
		mVolR    = '0;
		mXferCnt = '0;
		mIrqFlag = 1'b0;
		cdModelL = '0;
		cdModelR = '0;
		ringN    = '0;
		edgeCnt  = 0;
		buildTable();

		repeat (3) @(posedge clk);
		#1;
		checkFlag("o_dataOutValid", dataOutValid, 1'b0);
		checkFlag("o_SPUDREQ", spuDreq, 1'b0);
		checkFlag("o_SPUINT", spuInt, 1'b0);
		checkFlag("o_dataWriteRAM", dataWriteRam, 1'b0);
		checkFlag("o_validOut", validOut, 1'b0);
		rstN = 1'b1;

		for (stepIdx = 0; stepIdx < opQ.size(); stepIdx++)
		begin
			case (opQ[stepIdx])
				OP_WR:   writeReg(addrQ[stepIdx], dataQ[stepIdx]);
				OP_RD:   readReg(addrQ[stepIdx], expQ[stepIdx]);
				OP_FIFO: pushFifoWords(dataQ[stepIdx]);
				OP_DMA:  dmaWords(dataQ[stepIdx]);
				OP_IDLE: waitDrained();
				OP_CD:   driveCdPair(dataQ[stepIdx], expQ[stepIdx]);
				OP_TICK: checkDacTick();
				OP_INT:  checkFlag("o_SPUINT", spuInt, expQ[stepIdx][0]);
				default: ;
			endcase
		end

		// Let the last ring pair land
		repeat (4) @(posedge clk);
		if ((xferExpAddrQ.size() != 0) || (cdExpAddrQ.size() != 0))
		begin
			$display("Expected RAM writes never happened");
			stopOnError();
		end
		else
		begin
			$display("test passed");
			$finish;
		end
	end

endmodule

//--- verilog.f
+incdir+rtl
rtl/spu_pkg.sv
rtl/spu_regs.sv
rtl/spu_xfer_fifo.sv
rtl/spu_cd_capture.sv
rtl/spu_ram_port.sv
rtl/spu_top.sv
testbench/spu_tb.sv

//--- Bender.yml
package:
  name: spu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/spu_pkg.sv
      - rtl/spu_regs.sv
      - rtl/spu_xfer_fifo.sv
      - rtl/spu_cd_capture.sv
      - rtl/spu_ram_port.sv
      - rtl/spu_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/spu_tb.sv
